// File: design/hawk_defines.svh
/*
 * Hawk stall subsystem constants
 * AXI field widths, page geometry, ATT size and miss fill time
 */
`ifndef HAWK_DEFINES_SVH
`define HAWK_DEFINES_SVH

// AXI4 field widths
`define HAWK_AXI_ADDR_WIDTH 64
`define HAWK_AXI_DATA_WIDTH 64
`define HAWK_AXI_ID_WIDTH   4
`define HAWK_AXI_USER_WIDTH 1

// 4 KB pages, page number is address bits 59..12
`define HAWK_PAGE_SHIFT     12
`define HAWK_HPPA_WIDTH     48

// Direct-mapped ATT with 16 entries
`define HAWK_ATT_INDEX_BITS 4

// Cycles a miss waits before the page is installed
`define HAWK_FILL_CYCLES    8

`endif

// File: design/hawk_pkg.sv
/*
 * Hawk package
 * AXI channel payload structs and the hawk page request types
 */
`default_nettype none

`include "hawk_defines.svh"

package hawk_pkg;

    typedef logic [`HAWK_HPPA_WIDTH-1:0] hppa_t;
    typedef logic [`HAWK_HPPA_WIDTH-`HAWK_ATT_INDEX_BITS-1:0] att_tag_t;

    // AR and AW share one layout
    typedef struct packed {
        logic [`HAWK_AXI_ID_WIDTH-1:0]   id;
        logic [`HAWK_AXI_ADDR_WIDTH-1:0] addr;
        logic [7:0]                      len;
        logic [2:0]                      size;
        logic [1:0]                      burst;
        logic                            lock;
        logic [3:0]                      cache;
        logic [2:0]                      prot;
        logic [3:0]                      qos;
        logic [3:0]                      region;
        logic [`HAWK_AXI_USER_WIDTH-1:0] user;
    } axi_addr_t;

    typedef struct packed {
        logic [`HAWK_AXI_ID_WIDTH-1:0]   id;
        logic [`HAWK_AXI_DATA_WIDTH-1:0] data;
        logic [1:0]                      resp;
        logic                            last;
        logic [`HAWK_AXI_USER_WIDTH-1:0] user;
    } axi_r_t;

    typedef struct packed {
        logic [`HAWK_AXI_DATA_WIDTH-1:0]   data;
        logic [`HAWK_AXI_DATA_WIDTH/8-1:0] strb;
        logic                              last;
        logic [`HAWK_AXI_USER_WIDTH-1:0]   user;
    } axi_w_t;

    typedef struct packed {
        logic [`HAWK_AXI_ID_WIDTH-1:0]   id;
        logic [1:0]                      resp;
        logic [`HAWK_AXI_USER_WIDTH-1:0] user;
    } axi_b_t;

    // Page request from a stall bridge, valid for one cycle
    typedef struct packed {
        logic  valid;
        hppa_t hppa;
    } cpu_reqpkt_t;

    typedef struct packed {
        logic     valid;
        att_tag_t tag;
    } att_entry_t;

    typedef struct packed {
        logic [15:0] hit_count;
        logic [15:0] miss_count;
    } hawk_stats_t;

endpackage

`default_nettype wire

// File: design/hawk_att.sv
/*
 * Hawk address translation table
 * Direct-mapped page table with registered lookup and single-entry install
 */
`timescale 1ns/100ps
`default_nettype none

`include "hawk_defines.svh"

module hawk_att (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  lookup,
    input  wire hawk_pkg::hppa_t lookup_hppa,
    output logic                 hit,
    input  wire                  install,
    input  wire hawk_pkg::hppa_t install_hppa
);

    import hawk_pkg::*;

    localparam int unsigned IDX_W   = `HAWK_ATT_INDEX_BITS;
    localparam int unsigned ENTRIES = 1 << IDX_W;

    att_entry_t       entry_q [ENTRIES];
    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] install_idx;
    att_tag_t         lookup_tag;
    att_tag_t         install_tag;

    // Low page bits select the entry, the rest form the tag
    assign lookup_idx  = lookup_hppa[IDX_W-1:0];
    assign lookup_tag  = lookup_hppa[`HAWK_HPPA_WIDTH-1:IDX_W];
    assign install_idx = install_hppa[IDX_W-1:0];
    assign install_tag = install_hppa[`HAWK_HPPA_WIDTH-1:IDX_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
            for (int i = 0; i < ENTRIES; i++) begin
                entry_q[i] <= '0;
            end
        end else begin
            hit <= lookup
                && entry_q[lookup_idx].valid
                && (entry_q[lookup_idx].tag == lookup_tag);

            // Overwrite evicts whatever page held this index
            if (install) begin
                entry_q[install_idx] <= '{valid: 1'b1, tag: install_tag};
            end
        end
    end

endmodule

`default_nettype wire

// File: design/hawk_ctrl_unit.sv
/*
 * Hawk control unit
 * Serves page requests from the read and write bridges oldest first,
 * checks the ATT, models the miss fill and grants access
 */
`timescale 1ns/100ps
`default_nettype none

`include "hawk_defines.svh"

module hawk_ctrl_unit (
    input  wire                         clk,
    input  wire                         rst,
    input  wire hawk_pkg::cpu_reqpkt_t  rd_reqpkt,
    input  wire hawk_pkg::cpu_reqpkt_t  wr_reqpkt,
    output logic                        rd_allow,
    output logic                        wr_allow,
    output logic                        att_lookup,
    output hawk_pkg::hppa_t             att_lookup_hppa,
    input  wire                         att_hit,
    output logic                        att_install,
    output hawk_pkg::hppa_t             att_install_hppa,
    output hawk_pkg::hawk_stats_t       stats
);

    import hawk_pkg::*;

    localparam int unsigned FILL_W = $clog2(`HAWK_FILL_CYCLES + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_CHECK,
        ST_FILL
    } state_t;

    state_t            state_q;
    logic              rd_pend_q, wr_pend_q;
    hppa_t             rd_hppa_q, wr_hppa_q;
    hppa_t             cur_hppa_q;
    logic              rd_first_q;
    logic              owner_rd_q;
    logic [FILL_W-1:0] fill_cnt_q;
    logic              rd_req, wr_req;
    hppa_t             rd_sel_hppa, wr_sel_hppa;
    logic              rd_older;
    logic              take_rd, take_wr;
    logic              hit_grant, fill_done, grant;

    // A request can be served in the very cycle its packet arrives
    assign rd_req      = rd_pend_q || rd_reqpkt.valid;
    assign wr_req      = wr_pend_q || wr_reqpkt.valid;
    assign rd_sel_hppa = rd_reqpkt.valid ? rd_reqpkt.hppa : rd_hppa_q;
    assign wr_sel_hppa = wr_reqpkt.valid ? wr_reqpkt.hppa : wr_hppa_q;

    // A waiting write is older than a fresh read; otherwise read wins ties
    assign rd_older = wr_pend_q ? (rd_pend_q && rd_first_q) : 1'b1;
    assign take_rd  = (state_q == ST_IDLE) && rd_req && (!wr_req || rd_older);
    assign take_wr  = (state_q == ST_IDLE) && wr_req && !take_rd;

    assign hit_grant = (state_q == ST_CHECK) && att_hit;
    assign fill_done = (state_q == ST_FILL) && (fill_cnt_q == '0);
    assign grant     = hit_grant || fill_done;

    assign rd_allow         = grant && owner_rd_q;
    assign wr_allow         = grant && !owner_rd_q;
    assign att_lookup       = (state_q == ST_LOOKUP);
    assign att_lookup_hppa  = cur_hppa_q;
    assign att_install      = fill_done;
    assign att_install_hppa = cur_hppa_q;

    always_ff @(posedge clk) begin
        if (rd_reqpkt.valid) rd_hppa_q <= rd_reqpkt.hppa;
        if (wr_reqpkt.valid) wr_hppa_q <= wr_reqpkt.hppa;
        if (take_rd) begin
            cur_hppa_q <= rd_sel_hppa;
        end else if (take_wr) begin
            cur_hppa_q <= wr_sel_hppa;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            rd_pend_q  <= 1'b0;
            wr_pend_q  <= 1'b0;
            rd_first_q <= 1'b1;
            owner_rd_q <= 1'b0;
            fill_cnt_q <= '0;
            stats      <= '0;
        end else begin
            rd_pend_q <= rd_req && !take_rd;
            wr_pend_q <= wr_req && !take_wr;

            // Age flag records which side was waiting first
            if (rd_reqpkt.valid && wr_reqpkt.valid) begin
                rd_first_q <= 1'b1;
            end else if (rd_reqpkt.valid) begin
                rd_first_q <= !wr_pend_q;
            end else if (wr_reqpkt.valid) begin
                rd_first_q <= rd_pend_q;
            end

            case (state_q)
                ST_IDLE: begin
                    if (take_rd || take_wr) begin
                        owner_rd_q <= take_rd;
                        state_q    <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: state_q <= ST_CHECK;
                ST_CHECK: begin
                    if (att_hit) begin
                        state_q <= ST_IDLE;
                    end else begin
                        fill_cnt_q <= FILL_W'(`HAWK_FILL_CYCLES - 1);
                        state_q    <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (fill_done) begin
                        state_q <= ST_IDLE;
                    end else begin
                        fill_cnt_q <= fill_cnt_q - 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase

            // Saturating event counters
            if (hit_grant && (stats.hit_count != '1)) begin
                stats.hit_count <= stats.hit_count + 16'd1;
            end
            if (fill_done && (stats.miss_count != '1)) begin
                stats.miss_count <= stats.miss_count + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/hawk_cpu_stall.sv
/*
 * Hawk CPU stall bridge
 * Holds one AXI address request until the control unit grants access,
 * then forwards it and blocks new requests until its response is done
 */
`timescale 1ns/100ps
`default_nettype none

`include "hawk_defines.svh"

module hawk_cpu_stall #(
    parameter type chan_t = hawk_pkg::axi_addr_t
) (
    input  wire                   clk,
    input  wire                   rst,

    // CPU side address channel
    input  wire chan_t            s_addr,
    input  wire                   s_valid,
    output logic                  s_ready,

    // Memory side address channel
    output chan_t                 m_addr,
    output logic                  m_valid,
    input  wire                   m_ready,

    // Hawk control unit
    input  wire                   allow_access,
    input  wire                   rsp_done,
    output hawk_pkg::cpu_reqpkt_t reqpkt
);

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } state_t;

    state_t state_q;
    logic   pending_q;
    logic   req_valid_q;
    logic   s_hs;
    logic   grant;

    // Accept only when idle, nothing queued to memory and no response outstanding
    assign s_ready = (state_q == ST_IDLE) && !m_valid && !pending_q;
    assign s_hs    = s_valid && s_ready;

    // The allow pulse is used in the same cycle so that m_valid follows it by one cycle
    assign grant = (state_q == ST_WAIT) && allow_access;

    // Captured request, held on the master channel until accepted
    always_ff @(posedge clk) begin
        if (s_hs) begin
            m_addr <= s_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            m_valid     <= 1'b0;
            pending_q   <= 1'b0;
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= s_hs;

            if (m_valid && m_ready) begin
                m_valid <= 1'b0;
            end

            case (state_q)
                ST_IDLE: begin
                    if (s_hs) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (grant) begin
                        m_valid <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase

            // One transaction in flight until its response completes
            if (grant) begin
                pending_q <= 1'b1;
            end else if (rsp_done) begin
                pending_q <= 1'b0;
            end
        end
    end

    // Page number of the captured request, valid the cycle after the handshake
    assign reqpkt = '{
        valid: req_valid_q,
        hppa:  m_addr.addr[`HAWK_PAGE_SHIFT+`HAWK_HPPA_WIDTH-1:`HAWK_PAGE_SHIFT]
    };

endmodule

`default_nettype wire

// File: design/hawk_top.sv
/*
 * Hawk CPU stall subsystem top
 * Read and write address bridges gated by the control unit and ATT,
 * data and response channels pass straight through
 */
`timescale 1ns/100ps
`default_nettype none

module hawk_top (
    input  wire                        clk,
    input  wire                        rst,

    // CPU slave side
    input  wire hawk_pkg::axi_addr_t   s_ar,
    input  wire                        s_arvalid,
    output wire                        s_arready,
    input  wire hawk_pkg::axi_addr_t   s_aw,
    input  wire                        s_awvalid,
    output wire                        s_awready,
    input  wire hawk_pkg::axi_w_t      s_w,
    input  wire                        s_wvalid,
    output wire                        s_wready,
    output wire hawk_pkg::axi_r_t      s_r,
    output wire                        s_rvalid,
    input  wire                        s_rready,
    output wire hawk_pkg::axi_b_t      s_b,
    output wire                        s_bvalid,
    input  wire                        s_bready,

    // Memory master side
    output wire hawk_pkg::axi_addr_t   m_ar,
    output wire                        m_arvalid,
    input  wire                        m_arready,
    output wire hawk_pkg::axi_addr_t   m_aw,
    output wire                        m_awvalid,
    input  wire                        m_awready,
    output wire hawk_pkg::axi_w_t      m_w,
    output wire                        m_wvalid,
    input  wire                        m_wready,
    input  wire hawk_pkg::axi_r_t      m_r,
    input  wire                        m_rvalid,
    output wire                        m_rready,
    input  wire hawk_pkg::axi_b_t      m_b,
    input  wire                        m_bvalid,
    output wire                        m_bready,

    output wire hawk_pkg::hawk_stats_t stats
);

    import hawk_pkg::*;

    cpu_reqpkt_t rd_reqpkt, wr_reqpkt;
    hppa_t       att_lookup_hppa, att_install_hppa;
    logic        rd_allow, wr_allow;
    logic        att_lookup, att_install, att_hit;
    logic        r_done, b_done;

    // Response completion releases the matching bridge
    assign r_done = m_rvalid && m_rready && m_r.last;
    assign b_done = m_bvalid && m_bready;

    assign m_w      = s_w;
    assign m_wvalid = s_wvalid;
    assign s_wready = m_wready;
    assign s_r      = m_r;
    assign s_rvalid = m_rvalid;
    assign m_rready = s_rready;
    assign s_b      = m_b;
    assign s_bvalid = m_bvalid;
    assign m_bready = s_bready;

    hawk_cpu_stall #(.chan_t(hawk_pkg::axi_addr_t)) u_rd_stall (
        .clk(clk), .rst(rst),
        .s_addr(s_ar), .s_valid(s_arvalid), .s_ready(s_arready),
        .m_addr(m_ar), .m_valid(m_arvalid), .m_ready(m_arready),
        .allow_access(rd_allow), .rsp_done(r_done), .reqpkt(rd_reqpkt)
    );

    hawk_cpu_stall #(.chan_t(hawk_pkg::axi_addr_t)) u_wr_stall (
        .clk(clk), .rst(rst),
        .s_addr(s_aw), .s_valid(s_awvalid), .s_ready(s_awready),
        .m_addr(m_aw), .m_valid(m_awvalid), .m_ready(m_awready),
        .allow_access(wr_allow), .rsp_done(b_done), .reqpkt(wr_reqpkt)
    );

    hawk_ctrl_unit u_ctrl (
        .clk(clk), .rst(rst),
        .rd_reqpkt(rd_reqpkt), .wr_reqpkt(wr_reqpkt),
        .rd_allow(rd_allow), .wr_allow(wr_allow),
        .att_lookup(att_lookup), .att_lookup_hppa(att_lookup_hppa),
        .att_hit(att_hit),
        .att_install(att_install), .att_install_hppa(att_install_hppa),
        .stats(stats)
    );

    hawk_att u_att (
        .clk(clk), .rst(rst),
        .lookup(att_lookup), .lookup_hppa(att_lookup_hppa), .hit(att_hit),
        .install(att_install), .install_hppa(att_install_hppa)
    );

endmodule

`default_nettype wire

// File: tb/hawk_tb.sv
/*
 * Hawk stall subsystem testbench
 * Random AXI read and write traffic, a memory responder and a reference ATT
 */
`timescale 1ns/100ps
`default_nettype none

`include "hawk_defines.svh"

module hawk_tb;

    import hawk_pkg::*;

    localparam int IDX_W      = `HAWK_ATT_INDEX_BITS;
    localparam int TAG_W      = `HAWK_HPPA_WIDTH - IDX_W;
    localparam int N_REQ      = 40;
    localparam int MAX_CYCLES = 20000;

    logic        clk, rst;
    axi_addr_t   s_ar, s_aw, m_ar, m_aw;
    logic        s_arvalid, s_arready, s_awvalid, s_awready;
    logic        m_arvalid, m_arready, m_awvalid, m_awready;
    axi_w_t      s_w, m_w;
    logic        s_wvalid, s_wready, m_wvalid, m_wready;
    axi_r_t      s_r, m_r;
    logic        s_rvalid, s_rready, m_rvalid, m_rready;
    axi_b_t      s_b, m_b;
    logic        s_bvalid, s_bready, m_bvalid, m_bready;
    hawk_stats_t stats;

    logic [31:0]      rng_state;
    int               cyc = 0;
    axi_addr_t        exp_ar[$], exp_aw[$];
    logic [TAG_W-1:0] model_tag [1 << IDX_W];
    bit               model_valid [1 << IDX_W];
    hawk_stats_t      model_stats = '0;
    int               rd_sent = 0, wr_sent = 0, rd_done = 0, wr_done = 0;
    int               rd_hs_cyc, wr_hs_cyc;
    bit               rd_miss, wr_miss, rd_seen, wr_seen, rd_busy, wr_busy;
    bit               ar_hold, aw_hold;
    axi_addr_t        ar_held, aw_held, r_req, b_req;
    int               r_beat = 0, r_total = 0, w_idx = 0, w_total = 0;
    bit               aw_got, w_last_got;
    bit               hs_ar, hs_aw, hs_mar, hs_maw, hs_w, hs_r, hs_b;

    hawk_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function logic [15:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    // Three tags over four indices, so pages hit, miss and evict each other
    function axi_addr_t make_request();
        axi_addr_t            a;
        logic [15:0]          r;
        logic [TAG_W+IDX_W-1:0] hppa;
        r        = next_rand();
        hppa     = {TAG_W'(44'h0a5c0 + r[1:0] % 3), IDX_W'(r[3:2] * 5)};
        a.id     = r[7:4];
        a.len    = 8'(r[9:8]);
        a.size   = 3'd3;
        a.burst  = 2'b01;
        a.lock   = r[10];
        a.cache  = r[14:11];
        r        = next_rand();
        a.prot   = r[2:0];
        a.qos    = r[6:3];
        a.region = r[10:7];
        a.user   = r[11];
        a.addr   = {r[15:12], hppa, 12'(next_rand())};
        return a;
    endfunction

    // Read data is a function of address and beat number
    function axi_r_t make_beat(input axi_addr_t a, input int beat);
        axi_r_t b;
        b.id   = a.id;
        b.data = a.addr ^ (64'h9e37_79b9_7f4a_7c15 * 64'(beat + 1));
        b.resp = 2'b00;
        b.last = (beat == int'(a.len));
        b.user = a.user;
        return b;
    endfunction

    // Reference ATT, returns 1 on a miss and installs the page
    function bit model_access(input logic [`HAWK_HPPA_WIDTH-1:0] hppa);
        logic [IDX_W-1:0] idx;
        idx = hppa[IDX_W-1:0];
        if (model_valid[idx] && model_tag[idx] == hppa[`HAWK_HPPA_WIDTH-1:IDX_W]) begin
            model_stats.hit_count = model_stats.hit_count + 16'd1;
            return 1'b0;
        end
        model_valid[idx] = 1'b1;
        model_tag[idx]   = hppa[`HAWK_HPPA_WIDTH-1:IDX_W];
        model_stats.miss_count = model_stats.miss_count + 16'd1;
        return 1'b1;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_addr(input axi_addr_t got, input axi_addr_t want, input string what);
        if (got !== want)
            abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                $time, what, got, want));
    endtask

    task automatic check_w(input axi_w_t got, input axi_w_t want, input string what);
        if (got !== want)
            abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                $time, what, got, want));
    endtask

    task automatic check_r(input axi_r_t got, input axi_r_t want, input string what);
        if (got !== want)
            abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                $time, what, got, want));
    endtask

    task automatic check_b(input axi_b_t got, input axi_b_t want, input string what);
        if (got !== want)
            abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                $time, what, got, want));
    endtask

    task automatic check_stats(input hawk_stats_t got, input hawk_stats_t want,
                               input string what);
        if (got !== want)
            abort_run($sformatf("CHECK FAILED at %0t: %s got %0d/%0d expected %0d/%0d",
                                $time, what, got.hit_count, got.miss_count,
                                want.hit_count, want.miss_count));
    endtask

    // Stability under stall, one request in flight, and miss latency
    task automatic watch_master(input axi_addr_t addr, input logic valid, input logic ready,
                                input bit miss, input int hs_cyc, input string name,
                                inout bit hold, inout axi_addr_t held,
                                inout bit seen, inout bit busy);
        if (hold && !(valid && addr === held))
            abort_run({name, " request changed or dropped while the memory stalled it"});
        hold = valid && !ready;
        held = addr;
        if (valid && !seen) begin
            seen = 1'b1;
            if (busy)
                abort_run({name, " request forwarded before the previous response completed"});
            if (miss && (cyc - hs_cyc < `HAWK_FILL_CYCLES))
                abort_run($sformatf("%s miss forwarded after only %0d cycles",
                                    name, cyc - hs_cyc));
        end
        if (valid && ready) begin
            seen = 1'b0;
            busy = 1'b1;
        end
    endtask

    // Taken mid-cycle, so these are the handshakes of the coming edge
    task automatic sample_cycle();
        hs_ar  = s_arvalid && s_arready;
        hs_aw  = s_awvalid && s_awready;
        hs_mar = m_arvalid && m_arready;
        hs_maw = m_awvalid && m_awready;
        hs_w   = s_wvalid && s_wready;
        hs_r   = s_rvalid && s_rready;
        hs_b   = s_bvalid && s_bready;
        // W, R and B are plain wires through the DUT
        if (m_wvalid !== s_wvalid || s_wready !== m_wready || s_rvalid !== m_rvalid
                || m_rready !== s_rready || s_bvalid !== m_bvalid || m_bready !== s_bready)
            abort_run("A W, R or B valid or ready does not pass straight through the DUT");
        // Read goes to the model first on a tie
        if (hs_ar) begin
            exp_ar.push_back(s_ar);
            rd_miss   = model_access(s_ar.addr[`HAWK_PAGE_SHIFT +: `HAWK_HPPA_WIDTH]);
            rd_hs_cyc = cyc + 1;
        end
        if (hs_aw) begin
            exp_aw.push_back(s_aw);
            wr_miss   = model_access(s_aw.addr[`HAWK_PAGE_SHIFT +: `HAWK_HPPA_WIDTH]);
            wr_hs_cyc = cyc + 1;
            w_total   = int'(s_aw.len) + 1;
            w_idx     = 0;
        end
        watch_master(m_ar, m_arvalid, m_arready, rd_miss, rd_hs_cyc, "read",
                     ar_hold, ar_held, rd_seen, rd_busy);
        watch_master(m_aw, m_awvalid, m_awready, wr_miss, wr_hs_cyc, "write",
                     aw_hold, aw_held, wr_seen, wr_busy);
        if (hs_mar) begin
            if (exp_ar.size() == 0)
                abort_run("Memory side saw a read request the CPU never sent");
            else
                check_addr(m_ar, exp_ar.pop_front(), "forwarded AR");
            r_req   = m_ar;
            r_beat  = 0;
            r_total = int'(m_ar.len) + 1;
        end
        if (hs_maw) begin
            if (exp_aw.size() == 0)
                abort_run("Memory side saw a write request the CPU never sent");
            else
                check_addr(m_aw, exp_aw.pop_front(), "forwarded AW");
            b_req  = m_aw;
            aw_got = 1'b1;
        end
        if (hs_w) begin
            check_w(m_w, s_w, "write data at memory");
            if (m_w.last)
                w_last_got = 1'b1;
        end
        if (hs_r) begin
            check_r(s_r, m_r, "read data at CPU");
            if (m_r.last) begin
                rd_busy = 1'b0;
                rd_done++;
            end
        end
        if (hs_b) begin
            check_b(s_b, m_b, "write response at CPU");
            wr_busy = 1'b0;
            wr_done++;
        end
    endtask

    task automatic drive_cycle();
        logic [15:0] r;
        logic [15:0] q;
        r = next_rand();
        q = next_rand();
        // CPU side
        if (hs_ar)
            s_arvalid = 1'b0;
        if (!s_arvalid && rd_sent < N_REQ && r[1:0] == 2'b00) begin
            s_ar      = make_request();
            s_arvalid = 1'b1;
            rd_sent++;
        end
        if (hs_aw)
            s_awvalid = 1'b0;
        if (!s_awvalid && wr_sent < N_REQ && r[3:2] == 2'b00) begin
            s_aw      = make_request();
            s_awvalid = 1'b1;
            wr_sent++;
        end
        if (hs_w) begin
            s_wvalid = 1'b0;
            w_idx++;
        end
        if (!s_wvalid && w_idx < w_total && r[4]) begin
            s_w.data = {next_rand(), next_rand(), next_rand(), next_rand()};
            s_w.strb = '1;
            s_w.last = (w_idx == w_total - 1);
            s_w.user = r[5];
            s_wvalid = 1'b1;
        end
        // Memory responder
        if (hs_r) begin
            m_rvalid = 1'b0;
            r_beat++;
        end
        if (!m_rvalid && r_beat < r_total && r[6]) begin
            m_r      = make_beat(r_req, r_beat);
            m_rvalid = 1'b1;
        end
        if (hs_b)
            m_bvalid = 1'b0;
        if (!m_bvalid && aw_got && w_last_got && r[7]) begin
            m_b        = '{id: b_req.id, resp: r[9:8], user: b_req.user};
            m_bvalid   = 1'b1;
            aw_got     = 1'b0;
            w_last_got = 1'b0;
        end
        m_arready = r[10] | r[11];
        m_awready = r[12] | r[13];
        m_wready  = r[14] | r[15];
        s_rready  = q[0] | q[1];
        s_bready  = q[2] | q[3];
    endtask

    initial begin
        rng_state = 32'h69707f0c;
        rst       = 1'b1;
        s_ar      = '0;
        s_arvalid = 1'b0;
        s_aw      = '0;
        s_awvalid = 1'b0;
        s_w       = '0;
        s_wvalid  = 1'b0;
        s_rready  = 1'b0;
        s_bready  = 1'b0;
        m_arready = 1'b0;
        m_awready = 1'b0;
        m_wready  = 1'b0;
        m_r       = '0;
        m_rvalid  = 1'b0;
        m_b       = '0;
        m_bvalid  = 1'b0;
        for (int i = 0; i < (1 << IDX_W); i++)
            model_valid[i] = 1'b0;

        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_stats(stats, '0, "counters after reset");
        if (m_arvalid || m_awvalid || s_rvalid || s_bvalid)
            abort_run("A valid output is high right after reset");

        while (rd_done < N_REQ || wr_done < N_REQ) begin
            @(posedge clk);
            cyc++;
            #1;
            drive_cycle();
            @(negedge clk);
            sample_cycle();
            if (cyc > MAX_CYCLES)
                abort_run($sformatf("Timeout with %0d reads and %0d writes completed",
                                    rd_done, wr_done));
        end

        check_stats(stats, model_stats, "final hit and miss counters");
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+design
design/hawk_pkg.sv
design/hawk_att.sv
design/hawk_ctrl_unit.sv
design/hawk_cpu_stall.sv
design/hawk_top.sv
tb/hawk_tb.sv
